//--- source/usb_hid_pkg.sv
// shared types and default constants for the low-speed HID receiver
// timing defaults assume a 12 MHz usbclk against a 1.5 Mb/s line
// CRC bytes are not checked and are treated as report bytes when they fit
`default_nettype none

package usb_hid_pkg;

    typedef logic [7:0]  hid_byte_t;    // one report byte
    typedef logic [2:0]  byte_idx_t;    // byte position within a report
    typedef logic [1:0]  hid_type_t;    // device class from enumeration
    typedef logic [63:0] hid_raw_t;     // whole report, byte 0 in the low bits

    // device types on dev_type
    localparam hid_type_t HID_NONE     = 2'd0;
    localparam hid_type_t HID_KEYBOARD = 2'd1;
    localparam hid_type_t HID_MOUSE    = 2'd2;
    localparam hid_type_t HID_GAMEPAD  = 2'd3;

    localparam int CLKS_PER_BIT     = 8;   // 12 MHz / 1.5 MHz
    localparam int SAMPLE_PHASE     = 4;   // roughly mid bit
    localparam int STUFF_RUN        = 6;   // ones before a stuffed zero
    localparam int HEADER_BITS      = 16;  // sync + PID
    localparam int MAX_REPORT_BYTES = 8;

    // framer FSM
    typedef enum logic [1:0] {
        RX_IDLE,
        RX_HEADER,
        RX_DATA,
        RX_DROP
    } rx_state_t;

endpackage

`default_nettype wire

//--- source/usb_line_rx.sv
// low-speed line receiver, listens only and never drives the bus
// bit timing comes from D- transitions, so SAMPLE_PHASE must be below CLK_DIV
// line takes J (D+ low, D- high) as idle and as the state before a packet
`default_nettype none

module usb_line_rx #(
    parameter int CLK_DIV = usb_hid_pkg::CLKS_PER_BIT
) (
    input  logic usbclk,
    input  logic usbrst_n,
    input  logic usb_dp,
    input  logic usb_dm,
    output logic sop,
    output logic bit_stb,
    output logic bit_val,
    output logic eop
);

    localparam int PW = $clog2(CLK_DIV + 1);

    logic [1:0]    dp_sync;
    logic [1:0]    dm_sync;
    logic          dm_d;       // D- one clock back
    logic          dm_smp;     // D- at previous sample
    logic [PW-1:0] phase;      // clocks since last D- edge
    logic [2:0]    ones_run;
    logic          in_pkt;

    logic dp;
    logic dm;
    logic dm_edge;
    logic smp;
    logic se0;
    logic nrz_bit;

    assign dp      = dp_sync[1];
    assign dm      = dm_sync[1];
    assign dm_edge = dm != dm_d;
    assign smp     = in_pkt && (phase == PW'(usb_hid_pkg::SAMPLE_PHASE));
    assign se0     = !dp && !dm;
    assign nrz_bit = dm == dm_smp;   // no change means a one

    always_ff @(posedge usbclk) begin
        if (!usbrst_n) begin
            dp_sync  <= 2'b00;
            dm_sync  <= 2'b11;       // idle J
            dm_d     <= 1'b1;
            dm_smp   <= 1'b1;
            phase    <= '0;
            ones_run <= '0;
            in_pkt   <= 1'b0;
            sop      <= 1'b0;
            bit_stb  <= 1'b0;
            bit_val  <= 1'b0;
            eop      <= 1'b0;
        end else begin
            dp_sync <= {dp_sync[0], usb_dp};
            dm_sync <= {dm_sync[0], usb_dm};
            dm_d    <= dm;
            sop     <= 1'b0;
            bit_stb <= 1'b0;
            eop     <= 1'b0;

            // bit clock recovery, one wrap per bit between edges
            if (dm_edge || phase == PW'(CLK_DIV)) begin
                phase <= PW'(1);
            end else begin
                phase <= phase + 1'b1;
            end

            if (!in_pkt && dm_edge && !dm && dp) begin   // J to K starts sync
                sop      <= 1'b1;
                in_pkt   <= 1'b1;
                ones_run <= '0;
                dm_smp   <= 1'b1;
            end else if (smp) begin
                if (se0) begin
                    eop    <= 1'b1;
                    in_pkt <= 1'b0;
                    dm_smp <= 1'b1;                      // line returns to J
                end else if (ones_run == 3'(usb_hid_pkg::STUFF_RUN)) begin
                    ones_run <= '0;                      // stuffed zero, dropped
                    dm_smp   <= dm;
                end else begin
                    bit_stb  <= 1'b1;
                    bit_val  <= nrz_bit;
                    ones_run <= nrz_bit ? ones_run + 1'b1 : 3'd0;
                    dm_smp   <= dm;
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- source/usb_packet_framer.sv
// byte assembly behind the line receiver
// sync and PID are skipped by bit count, the PID itself is not checked
// bytes past MAX_REPORT_BYTES are dropped until eop
`default_nettype none

module usb_packet_framer (
    input  logic                  usbclk,
    input  logic                  usbrst_n,
    input  logic                  sop,
    input  logic                  bit_stb,
    input  logic                  bit_val,
    input  logic                  eop,
    output logic                  byte_stb,
    output usb_hid_pkg::hid_byte_t byte_data,
    output usb_hid_pkg::byte_idx_t byte_idx,
    output logic                  pkt_end
);

    localparam int HW = $clog2(usb_hid_pkg::HEADER_BITS);

    usb_hid_pkg::rx_state_t state;
    logic [HW-1:0]          hdr_cnt;
    logic [2:0]             bit_pos;
    usb_hid_pkg::byte_idx_t byte_cnt;
    logic                   got_byte;   // at least one report byte sent
    usb_hid_pkg::hid_byte_t shift;
    logic                   byte_done;

    assign byte_done = (state == usb_hid_pkg::RX_DATA) && bit_stb && (bit_pos == 3'd7);

    // LSB first, new bit enters at the top
    always_ff @(posedge usbclk) begin
        if (state == usb_hid_pkg::RX_DATA && bit_stb) begin
            shift <= {bit_val, shift[7:1]};
        end
        if (byte_done) begin
            byte_data <= {bit_val, shift[7:1]};
            byte_idx  <= byte_cnt;
        end
    end

    always_ff @(posedge usbclk) begin
        if (!usbrst_n) begin
            state    <= usb_hid_pkg::RX_IDLE;
            hdr_cnt  <= '0;
            bit_pos  <= '0;
            byte_cnt <= '0;
            got_byte <= 1'b0;
            byte_stb <= 1'b0;
            pkt_end  <= 1'b0;
        end else begin
            byte_stb <= byte_done;
            pkt_end  <= 1'b0;
            if (eop) begin
                state    <= usb_hid_pkg::RX_IDLE;
                pkt_end  <= got_byte;             // header-only packets stay silent
                got_byte <= 1'b0;
            end else begin
                case (state)
                    usb_hid_pkg::RX_IDLE: if (sop) begin
                        state    <= usb_hid_pkg::RX_HEADER;
                        hdr_cnt  <= '0;
                        bit_pos  <= '0;
                        byte_cnt <= '0;
                    end
                    usb_hid_pkg::RX_HEADER: if (bit_stb) begin
                        hdr_cnt <= hdr_cnt + 1'b1;
                        if (hdr_cnt == HW'(usb_hid_pkg::HEADER_BITS - 1)) begin
                            state <= usb_hid_pkg::RX_DATA;
                        end
                    end
                    usb_hid_pkg::RX_DATA: if (bit_stb) begin
                        bit_pos <= bit_pos + 1'b1;
                        if (bit_pos == 3'd7) begin
                            got_byte <= 1'b1;
                            byte_cnt <= byte_cnt + 1'b1;
                            if (byte_cnt == 3'(usb_hid_pkg::MAX_REPORT_BYTES - 1)) begin
                                state <= usb_hid_pkg::RX_DROP;
                            end
                        end
                    end
                    default: ;                    // drop: wait for eop
                endcase
            end
        end
    end

endmodule

`default_nettype wire

//--- source/hid_report_decoder.sv
// keyboard and mouse fields plus the raw report copy
// dev_type is sampled per byte and may change only between packets
// mouse_dx and mouse_dy read as zero again one cycle after report
`default_nettype none

module hid_report_decoder (
    input  logic                   usbclk,
    input  logic                   usbrst_n,
    input  logic                   byte_stb,
    input  logic                   pkt_end,
    input  usb_hid_pkg::hid_byte_t  byte_data,
    input  usb_hid_pkg::byte_idx_t  byte_idx,
    input  usb_hid_pkg::hid_type_t  dev_type,
    output logic                   report,
    output usb_hid_pkg::hid_byte_t  key_modifiers,
    output usb_hid_pkg::hid_byte_t  key1,
    output usb_hid_pkg::hid_byte_t  key2,
    output usb_hid_pkg::hid_byte_t  key3,
    output usb_hid_pkg::hid_byte_t  key4,
    output usb_hid_pkg::hid_byte_t  mouse_btn,
    output usb_hid_pkg::hid_byte_t  mouse_dx,
    output usb_hid_pkg::hid_byte_t  mouse_dy,
    output usb_hid_pkg::hid_raw_t   hid_report
);

    always_ff @(posedge usbclk) begin
        if (!usbrst_n) begin
            report        <= 1'b0;
            key_modifiers <= '0;
            key1          <= '0;
            key2          <= '0;
            key3          <= '0;
            key4          <= '0;
            mouse_btn     <= '0;
            mouse_dx      <= '0;
            mouse_dy      <= '0;
            hid_report    <= '0;
        end else begin
            report <= pkt_end && (dev_type != usb_hid_pkg::HID_NONE);
            if (report) begin              // movement is relative, consume it
                mouse_dx <= '0;
                mouse_dy <= '0;
            end
            if (byte_stb) begin
                hid_report[{byte_idx, 3'b000} +: 8] <= byte_data;
                if (dev_type == usb_hid_pkg::HID_KEYBOARD) begin
                    case (byte_idx)        // byte 1 is reserved in boot reports
                        3'd0: key_modifiers <= byte_data;
                        3'd2: key1 <= byte_data;
                        3'd3: key2 <= byte_data;
                        3'd4: key3 <= byte_data;
                        3'd5: key4 <= byte_data;
                        default: ;
                    endcase
                end else if (dev_type == usb_hid_pkg::HID_MOUSE) begin
                    case (byte_idx)
                        3'd0: mouse_btn <= byte_data;   // middle, right, left
                        3'd1: mouse_dx <= byte_data;    // signed
                        3'd2: mouse_dy <= byte_data;
                        default: ;
                    endcase
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- source/hid_gamepad_decoder.sv
// gamepad directions and buttons for the common generic layout
// axes come from bytes 0/1 or from the top bits of bytes 3/4
// reports with byte 0 low bits 10 only touch the byte 0/1 axes
`default_nettype none

module hid_gamepad_decoder (
    input  logic                  usbclk,
    input  logic                  usbrst_n,
    input  logic                  byte_stb,
    input  logic                  pkt_end,
    input  usb_hid_pkg::hid_byte_t byte_data,
    input  usb_hid_pkg::byte_idx_t byte_idx,
    input  usb_hid_pkg::hid_type_t dev_type,
    output logic                  game_l,
    output logic                  game_r,
    output logic                  game_u,
    output logic                  game_d,
    output logic                  game_a,
    output logic                  game_b,
    output logic                  game_x,
    output logic                  game_y,
    output logic                  game_sel,
    output logic                  game_sta
);

    logic valid;   // current report has the usual layout

    always_ff @(posedge usbclk) begin
        if (!usbrst_n) begin
            valid <= 1'b0;
            {game_l, game_r, game_u, game_d} <= 4'b0000;
            {game_a, game_b, game_x, game_y} <= 4'b0000;
            {game_sel, game_sta} <= 2'b00;
        end else begin
            if (pkt_end) valid <= 1'b0;
            if (byte_stb && dev_type == usb_hid_pkg::HID_GAMEPAD) begin
                case (byte_idx)
                    3'd0: begin
                        if (byte_data[1:0] != 2'b10) begin
                            valid <= 1'b1;
                            {game_l, game_r, game_u, game_d} <= 4'b0000;
                        end else begin
                            valid <= 1'b0;   // adapter side record
                        end
                        if (byte_data == 8'h00) {game_l, game_r} <= 2'b10;
                        if (byte_data == 8'hff) {game_l, game_r} <= 2'b01;
                    end
                    3'd1: begin
                        if (byte_data == 8'h00) {game_u, game_d} <= 2'b10;
                        if (byte_data == 8'hff) {game_u, game_d} <= 2'b01;
                    end
                    3'd3: if (valid) begin
                        if (byte_data[7:6] == 2'b00) {game_l, game_r} <= 2'b10;
                        if (byte_data[7:6] == 2'b11) {game_l, game_r} <= 2'b01;
                    end
                    3'd4: if (valid) begin
                        if (byte_data[7:6] == 2'b00) {game_u, game_d} <= 2'b10;
                        if (byte_data[7:6] == 2'b11) {game_u, game_d} <= 2'b01;
                    end
                    3'd5: if (valid) {game_y, game_b, game_a, game_x} <= byte_data[7:4];
                    3'd6: if (valid) {game_sta, game_sel} <= byte_data[5:4];
                    default: ;
                endcase
            end
        end
    end

endmodule

`default_nettype wire

//--- source/usb_hid_rx.sv
// receive-only low-speed HID report decoder
// dev_type comes from outside enumeration logic and must be stable per packet
// no CRC check, no handshake back to the device
`default_nettype none

module usb_hid_rx #(
    parameter int CLKS_PER_BIT = usb_hid_pkg::CLKS_PER_BIT
) (
    input  logic                   usbclk,
    input  logic                   usbrst_n,
    input  logic                   usb_dp,
    input  logic                   usb_dm,
    input  usb_hid_pkg::hid_type_t  dev_type,
    output logic                   report,
    output usb_hid_pkg::hid_byte_t  key_modifiers,
    output usb_hid_pkg::hid_byte_t  key1,
    output usb_hid_pkg::hid_byte_t  key2,
    output usb_hid_pkg::hid_byte_t  key3,
    output usb_hid_pkg::hid_byte_t  key4,
    output usb_hid_pkg::hid_byte_t  mouse_btn,
    output usb_hid_pkg::hid_byte_t  mouse_dx,
    output usb_hid_pkg::hid_byte_t  mouse_dy,
    output usb_hid_pkg::hid_raw_t   hid_report,
    output logic                   game_l,
    output logic                   game_r,
    output logic                   game_u,
    output logic                   game_d,
    output logic                   game_a,
    output logic                   game_b,
    output logic                   game_x,
    output logic                   game_y,
    output logic                   game_sel,
    output logic                   game_sta
);

    logic                   sop;
    logic                   bit_stb;
    logic                   bit_val;
    logic                   eop;
    logic                   byte_stb;
    usb_hid_pkg::hid_byte_t byte_data;
    usb_hid_pkg::byte_idx_t byte_idx;
    logic                   pkt_end;

    usb_line_rx #(
        .CLK_DIV (CLKS_PER_BIT)
    ) u_line_rx (
        .usbclk, .usbrst_n, .usb_dp, .usb_dm,
        .sop, .bit_stb, .bit_val, .eop
    );

    usb_packet_framer u_framer (
        .usbclk, .usbrst_n, .sop, .bit_stb, .bit_val, .eop,
        .byte_stb, .byte_data, .byte_idx, .pkt_end
    );

    hid_report_decoder u_report_dec (
        .usbclk, .usbrst_n, .byte_stb, .pkt_end, .byte_data, .byte_idx, .dev_type,
        .report, .key_modifiers, .key1, .key2, .key3, .key4,
        .mouse_btn, .mouse_dx, .mouse_dy, .hid_report
    );

    hid_gamepad_decoder u_gamepad_dec (
        .usbclk, .usbrst_n, .byte_stb, .pkt_end, .byte_data, .byte_idx, .dev_type,
        .game_l, .game_r, .game_u, .game_d,
        .game_a, .game_b, .game_x, .game_y, .game_sel, .game_sta
    );

endmodule

`default_nettype wire

//--- tests/usb_host_model.svh
// low-speed device side of the bus, drives usb_dp and usb_dm from the testbench
// needs usbclk, usb_dp, usb_dm and CLKS_PER_BIT declared in the including module
// J is D+ low and D- high, no CRC is generated
`ifndef USB_HOST_MODEL_SVH
`define USB_HOST_MODEL_SVH

logic line_k;   // NRZI line state, 1 while K

// set both pins on a rising edge and hold them for whole bit times
task automatic hold_line(input logic dp, input logic dm, input int bits);
    @(posedge usbclk);
    usb_dp <= dp;
    usb_dm <= dm;
    repeat (bits * CLKS_PER_BIT - 1) @(posedge usbclk);
endtask

task automatic send_nrzi_bit(input logic b);
    if (!b) begin
        line_k = !line_k;   // zero toggles the line
    end
    hold_line(line_k, !line_k, 1);
endtask

// LSB first, stuffed zero after six ones in a row
task automatic send_byte_bits(input logic [7:0] val, inout int ones);
    for (int i = 0; i < 8; i++) begin
        send_nrzi_bit(val[i]);
        ones = val[i] ? ones + 1 : 0;
        if (ones == usb_hid_pkg::STUFF_RUN) begin
            send_nrzi_bit(1'b0);
            ones = 0;
        end
    end
endtask

task automatic send_packet(input logic [7:0] pid, input usb_hid_pkg::hid_byte_t payload[$]);
    int ones;
    ones = 0;
    line_k = 1'b0;                  // starts from idle J
    send_byte_bits(8'h80, ones);    // sync KJKJKJKK
    send_byte_bits(pid, ones);
    foreach (payload[i]) begin
        send_byte_bits(payload[i], ones);
    end
    hold_line(1'b0, 1'b0, 2);       // SE0
    hold_line(1'b0, 1'b1, 1);       // back to J
endtask

`endif

//--- tests/tb_usb_hid_rx.sv
// directed testbench for the low-speed HID receiver
// expected fields are rebuilt from the sent bytes and dev_type
// pins are sampled by the DUT, outputs are checked on the falling clock edge
`default_nettype none

module tb_usb_hid_rx;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int CLKS_PER_BIT = usb_hid_pkg::CLKS_PER_BIT;
    // 20 packets of up to 14 bytes, 20 percent stuffing margin
    localparam int TIMEOUT_CYCLES = 20 * 14 * 8 * 12 / 10 * CLKS_PER_BIT + 1000;
    localparam logic [7:0] PID_DATA0 = 8'hc3;
    localparam logic [7:0] PID_DATA1 = 8'h4b;

    logic                   usbclk;
    logic                   usbrst_n;
    logic                   usb_dp;
    logic                   usb_dm;
    usb_hid_pkg::hid_type_t dev_type;
    logic                   report;
    usb_hid_pkg::hid_byte_t key_modifiers;
    usb_hid_pkg::hid_byte_t key1;
    usb_hid_pkg::hid_byte_t key2;
    usb_hid_pkg::hid_byte_t key3;
    usb_hid_pkg::hid_byte_t key4;
    usb_hid_pkg::hid_byte_t mouse_btn;
    usb_hid_pkg::hid_byte_t mouse_dx;
    usb_hid_pkg::hid_byte_t mouse_dy;
    usb_hid_pkg::hid_raw_t  hid_report;
    logic game_l, game_r, game_u, game_d;
    logic game_a, game_b, game_x, game_y;
    logic game_sel, game_sta;

    int err_cnt      = 0;
    int tests_run    = 0;
    int tests_failed = 0;
    int report_cnt   = 0;
    int cycle_cnt    = 0;

    logic                   report_d = 1'b0;
    usb_hid_pkg::hid_byte_t seen_btn, seen_dx, seen_dy;   // taken while report is high
    usb_hid_pkg::hid_byte_t after_dx, after_dy;           // one cycle later

    usb_hid_pkg::hid_raw_t  exp_raw;
    usb_hid_pkg::hid_byte_t exp_mod, exp_k1, exp_k2, exp_k3, exp_k4, exp_btn;

    `include "usb_host_model.svh"

    usb_hid_rx #(
        .CLKS_PER_BIT (CLKS_PER_BIT)
    ) uut (.*);

    initial begin
        usbclk = 1'b0;
        forever #10 usbclk = ~usbclk;
    end

    always @(negedge usbclk) begin
        if (report_d) begin
            after_dx = mouse_dx;
            after_dy = mouse_dy;
        end
        if (report) begin
            report_cnt = report_cnt + 1;
            seen_btn   = mouse_btn;
            seen_dx    = mouse_dx;
            seen_dy    = mouse_dy;
        end
        report_d = report;
    end

    always @(posedge usbclk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Something failed");
            $finish;
        end
    end

    task automatic check_byte(input string what, input usb_hid_pkg::hid_byte_t got,
                              input usb_hid_pkg::hid_byte_t exp);
        if (got !== exp) begin
            err_cnt++;
            $display("MISMATCH at %0d ns: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_raw(input string what, input usb_hid_pkg::hid_raw_t got,
                             input usb_hid_pkg::hid_raw_t exp);
        if (got !== exp) begin
            err_cnt++;
            $display("MISMATCH at %0d ns: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_bit(input string what, input logic got, input logic exp);
        if (got !== exp) begin
            err_cnt++;
            $display("MISMATCH at %0d ns: %s is %b, expected %b", $time, what, got, exp);
        end
    endtask

    // one pulse per packet with report bytes, none for HID_NONE
    task automatic check_report_count(input string what, input usb_hid_pkg::hid_type_t dev,
                                      input logic had_bytes, input int got);
        int exp;
        exp = (had_bytes && dev != usb_hid_pkg::HID_NONE) ? 1 : 0;
        if (got != exp) begin
            err_cnt++;
            if (got == 0) begin
                $display("%s: no report pulse within 2 bit times after EOP", what);
            end else begin
                $display("MISMATCH at %0d ns: %s gave %0d report pulses, expected %0d",
                         $time, what, got, exp);
            end
        end
    endtask

    // expected state from the sent bytes
    task automatic model_packet(input usb_hid_pkg::hid_type_t dev,
                                input usb_hid_pkg::hid_byte_t q[$]);
        for (int i = 0; i < q.size() && i < usb_hid_pkg::MAX_REPORT_BYTES; i++) begin
            exp_raw = (exp_raw & ~(64'hff << (8 * i))) | (64'(q[i]) << (8 * i));
            if (dev == usb_hid_pkg::HID_KEYBOARD) begin
                case (i)
                    0: exp_mod = q[i];
                    2: exp_k1 = q[i];
                    3: exp_k2 = q[i];
                    4: exp_k3 = q[i];
                    5: exp_k4 = q[i];
                    default: ;
                endcase
            end
            if (dev == usb_hid_pkg::HID_MOUSE && i == 0) begin
                exp_btn = q[i];
            end
        end
    endtask

    task automatic run_packet(input string what, input usb_hid_pkg::hid_type_t dev,
                              input logic [7:0] pid, input usb_hid_pkg::hid_byte_t q[$]);
        int start;
        int n;
        @(posedge usbclk);
        dev_type <= dev;
        model_packet(dev, q);
        start = report_cnt;
        send_packet(pid, q);
        n = 0;
        // the trailing J already used one of the two bit times
        while (report_cnt == start && n < CLKS_PER_BIT) begin
            @(posedge usbclk);
            n++;
        end
        repeat (4) @(posedge usbclk);   // room for a stray second pulse
        check_report_count(what, dev, q.size() > 0, report_cnt - start);
    endtask

    task automatic check_outputs(input string what);
        @(negedge usbclk);
        check_raw({what, " hid_report"}, hid_report, exp_raw);
        check_byte({what, " key_modifiers"}, key_modifiers, exp_mod);
        check_byte({what, " key1"}, key1, exp_k1);
        check_byte({what, " key2"}, key2, exp_k2);
        check_byte({what, " key3"}, key3, exp_k3);
        check_byte({what, " key4"}, key4, exp_k4);
        check_byte({what, " mouse_btn"}, mouse_btn, exp_btn);
        check_byte({what, " mouse_dx"}, mouse_dx, 8'h00);
        check_byte({what, " mouse_dy"}, mouse_dy, 8'h00);
    endtask

    // exp order: l r u d a b x y sel sta
    task automatic check_pad(input string what, input logic [9:0] exp);
        @(negedge usbclk);
        check_bit({what, " game_l"}, game_l, exp[9]);
        check_bit({what, " game_r"}, game_r, exp[8]);
        check_bit({what, " game_u"}, game_u, exp[7]);
        check_bit({what, " game_d"}, game_d, exp[6]);
        check_bit({what, " game_a"}, game_a, exp[5]);
        check_bit({what, " game_b"}, game_b, exp[4]);
        check_bit({what, " game_x"}, game_x, exp[3]);
        check_bit({what, " game_y"}, game_y, exp[2]);
        check_bit({what, " game_sel"}, game_sel, exp[1]);
        check_bit({what, " game_sta"}, game_sta, exp[0]);
    endtask

    task automatic end_test(input string what, input int start_err);
        tests_run++;
        if (err_cnt == start_err) begin
            $display("test %s: passed", what);
        end else begin
            tests_failed++;
            $display("test %s: failed with %0d errors", what, err_cnt - start_err);
        end
    endtask

    task automatic test_keyboard();
        int e;
        usb_hid_pkg::hid_byte_t q[$];
        e = err_cnt;
        @(negedge usbclk);
        check_raw("hid_report after reset", hid_report, '0);
        check_bit("report after reset", report, 1'b0);
        q = {8'h02, 8'h00, 8'h04, 8'h16, 8'h1a, 8'h2c, 8'h5a, 8'ha5};
        run_packet("keyboard", usb_hid_pkg::HID_KEYBOARD, PID_DATA0, q);
        check_outputs("keyboard");
        end_test("keyboard", e);
    endtask

    task automatic test_mouse();
        int e;
        usb_hid_pkg::hid_byte_t q[$];
        e = err_cnt;
        q = {8'h05, 8'h0c, 8'hf4, 8'h01, 8'($urandom), 8'($urandom)};   // last two stand in for CRC
        run_packet("mouse", usb_hid_pkg::HID_MOUSE, PID_DATA1, q);
        check_byte("mouse_btn at report", seen_btn, q[0]);
        check_byte("mouse_dx at report", seen_dx, q[1]);
        check_byte("mouse_dy at report", seen_dy, q[2]);
        check_byte("mouse_dx after report", after_dx, 8'h00);
        check_byte("mouse_dy after report", after_dy, 8'h00);
        check_outputs("mouse");
        end_test("mouse", e);
    endtask

    task automatic test_gamepad();
        int e;
        usb_hid_pkg::hid_byte_t q[$];
        e = err_cnt;
        q = {8'h00, 8'h80, 8'h00, 8'h80, 8'h80, 8'ha0, 8'h10, 8'h00};
        run_packet("gamepad left", usb_hid_pkg::HID_GAMEPAD, PID_DATA0, q);
        check_pad("gamepad left", 10'b1000_1001_10);
        q = {8'h01, 8'h80, 8'h00, 8'hc0, 8'h00, 8'h50, 8'h20, 8'h00};
        run_packet("gamepad right", usb_hid_pkg::HID_GAMEPAD, PID_DATA1, q);
        check_pad("gamepad right", 10'b0110_0110_01);
        q = {8'h02, 8'h80, 8'h00, 8'h00, 8'hc0, 8'hf0, 8'h30, 8'h00};   // other layout
        run_packet("gamepad invalid", usb_hid_pkg::HID_GAMEPAD, PID_DATA0, q);
        check_pad("gamepad invalid", 10'b0110_0110_01);
        check_outputs("gamepad");
        end_test("gamepad", e);
    endtask

    task automatic test_stuffing();
        int e;
        usb_hid_pkg::hid_byte_t q[$];
        e = err_cnt;
        q = {8'hff, 8'hff, 8'hff, 8'hff, 8'hff, 8'hff, 8'hff, 8'hff};
        run_packet("stuffing ff", usb_hid_pkg::HID_KEYBOARD, PID_DATA1, q);
        check_outputs("stuffing ff");
        q = {8'h7e, 8'hff, 8'h3f, 8'hfc, 8'h00, 8'hff, 8'hfe, 8'h01};
        run_packet("stuffing mixed", usb_hid_pkg::HID_KEYBOARD, PID_DATA0, q);
        check_outputs("stuffing mixed");
        for (int k = 0; k < 3; k++) begin
            q.delete();
            for (int i = 0; i < 8; i++) begin
                q.push_back(8'($urandom));
            end
            run_packet("stuffing random", usb_hid_pkg::HID_KEYBOARD, PID_DATA1, q);
            check_outputs("stuffing random");
        end
        end_test("bit stuffing", e);
    endtask

    task automatic test_no_report();
        int e;
        usb_hid_pkg::hid_byte_t q[$];
        e = err_cnt;
        q = {8'h11, 8'h22, 8'h33, 8'h44, 8'h55, 8'h66, 8'h77, 8'h88};
        run_packet("no device type", usb_hid_pkg::HID_NONE, PID_DATA0, q);
        check_outputs("no device type");
        q.delete();   // sync and PID only
        run_packet("header only", usb_hid_pkg::HID_KEYBOARD, PID_DATA1, q);
        check_outputs("header only");
        end_test("no report", e);
    endtask

    initial begin
        usbrst_n = 1'b0;
        usb_dp   = 1'b0;   // idle J
        usb_dm   = 1'b1;
        dev_type = usb_hid_pkg::HID_NONE;
        line_k   = 1'b0;
        exp_raw  = '0;
        exp_mod  = '0;
        exp_k1   = '0;
        exp_k2   = '0;
        exp_k3   = '0;
        exp_k4   = '0;
        exp_btn  = '0;
        void'($urandom(85));
        repeat (16) @(posedge usbclk);
        usbrst_n <= 1'b1;
        repeat (4) @(posedge usbclk);

        test_keyboard();
        test_mouse();
        test_gamepad();
        test_stuffing();
        test_no_report();

        $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, err_cnt);
        if (err_cnt == 0 && tests_failed == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- usb_hid_rx.f
+incdir+tests
source/usb_hid_pkg.sv
source/usb_line_rx.sv
source/usb_packet_framer.sv
source/hid_report_decoder.sv
source/hid_gamepad_decoder.sv
source/usb_hid_rx.sv
tests/tb_usb_hid_rx.sv

//--- build.sh
#!/bin/sh
# compile and run the usb_hid_rx testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing -f usb_hid_rx.f --top-module tb_usb_hid_rx -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "build.sh: Verilator compile failed"
    exit 1
fi

./obj_dir/Vtb_usb_hid_rx > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "build.sh: simulation exited with status $status"
    exit 1
fi

if grep -q "Something failed" "$LOG"; then
    echo "build.sh: testbench reported failure"
    exit 1
fi

echo "build.sh: simulation passed"
exit 0
